// File: common/redmule_ctrl_pkg.sv
// Controller widths, register map and phase FSM state encoding
`default_nettype none

package redmule_ctrl_pkg;

  // Row and store counts
  typedef logic [15:0] cnt_t;

  // Register port address and data
  typedef logic [2:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Register map
  localparam reg_addr_t ADDR_TRIGGER    = 3'd0;
  localparam reg_addr_t ADDR_W_ITERS    = 3'd1;
  localparam reg_addr_t ADDR_TOT_STORES = 3'd2;
  localparam reg_addr_t ADDR_STATUS     = 3'd3;
  localparam reg_addr_t ADDR_CLEAR      = 3'd4;

  // Job phases, in sequence order
  typedef enum logic [2:0] {
    IDLE,
    STARTING,
    COMPUTING,
    BUFFERING,
    STORING,
    FINISHED
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/ctrl_regfile.sv
// Configuration registers, trigger and soft clear pulses, status readback
`timescale 1ns/1ps
`default_nettype none

module ctrl_regfile (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_we_i,
  input  logic                        cfg_re_i,
  input  redmule_ctrl_pkg::reg_addr_t cfg_addr_i,
  input  redmule_ctrl_pkg::reg_data_t cfg_wdata_i,
  output redmule_ctrl_pkg::reg_data_t cfg_rdata_o,
  input  logic                        busy_i,
  input  logic                        done_i,
  output logic                        clear_o,
  output logic                        start_o,
  output redmule_ctrl_pkg::cnt_t      w_iters_o,
  output redmule_ctrl_pkg::cnt_t      tot_stores_o
);

  redmule_ctrl_pkg::cnt_t w_iters_q;
  redmule_ctrl_pkg::cnt_t tot_stores_q;
  logic                   start_q;
  logic                   clear_q;
  logic                   done_q;
  logic                   trig_wr;
  logic                   clear_wr;

  assign trig_wr  = cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_TRIGGER);
  assign clear_wr = cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_CLEAR);

  // Job configuration, kept across a soft clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_iters_q    <= '0;
      tot_stores_q <= '0;
    end else if (cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_W_ITERS)) begin
      w_iters_q <= cfg_wdata_i[15:0];
    end else if (cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_TOT_STORES)) begin
      tot_stores_q <= cfg_wdata_i[15:0];
    end
  end

  // Single-cycle pulses, one cycle after the write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      start_q <= trig_wr;
      clear_q <= clear_wr;
    end
  end

  // Sticky done, dropped when the next job starts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_q || clear_q) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  always_comb begin
    cfg_rdata_o = '0;
    if (cfg_re_i) begin
      case (cfg_addr_i)
        redmule_ctrl_pkg::ADDR_W_ITERS:    cfg_rdata_o = {16'b0, w_iters_q};
        redmule_ctrl_pkg::ADDR_TOT_STORES: cfg_rdata_o = {16'b0, tot_stores_q};
        redmule_ctrl_pkg::ADDR_STATUS:     cfg_rdata_o = {30'b0, done_q, busy_i};
        default:                           cfg_rdata_o = '0;
      endcase
    end
  end

  assign clear_o      = clear_q;
  assign start_o      = start_q;
  assign w_iters_o    = w_iters_q;
  assign tot_stores_o = tot_stores_q;

endmodule

`default_nettype wire

// File: verilog/row_tracker.sv
// Weight row counter, computed weight counter, last row flag and tile flags
`timescale 1ns/1ps
`default_nettype none

module row_tracker #(
  parameter int unsigned Height = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  redmule_ctrl_pkg::cnt_t w_iters_i,
  input  logic                   w_loaded_i,
  input  logic                   reg_enable_i,
  input  logic                   row_inc_i,
  input  logic                   row_set_one_i,
  input  logic                   row_clr_i,
  input  logic                   count_w_set_i,
  input  logic                   count_w_clr_i,
  input  logic                   last_row_set_i,
  input  logic                   last_row_clr_i,
  output logic                   rows_reached_height_o,
  output logic                   rows_at_iters_o,
  output logic                   count_w_o,
  output logic                   last_w_row_o,
  output logic                   tile_row_done_o,
  output logic                   last_tile_done_o
);

  localparam redmule_ctrl_pkg::cnt_t height_cnt    = redmule_ctrl_pkg::cnt_t'(Height);
  localparam redmule_ctrl_pkg::cnt_t tile_end_cnt  = redmule_ctrl_pkg::cnt_t'(Height - 1);
  localparam redmule_ctrl_pkg::cnt_t last_tile_cnt = redmule_ctrl_pkg::cnt_t'(Height - 2);

  redmule_ctrl_pkg::cnt_t row_q;
  redmule_ctrl_pkg::cnt_t row_inc_d;
  redmule_ctrl_pkg::cnt_t computed_q;
  logic                   count_w_q;
  logic                   last_w_row_q;

  // Row count including a load seen this cycle
  assign row_inc_d = (row_inc_i && w_loaded_i) ? row_q + 16'd1 : row_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q <= '0;
    end else if (clear_i || row_clr_i) begin
      row_q <= '0;
    end else if (row_set_one_i) begin
      row_q <= 16'd1;
    end else begin
      row_q <= row_inc_d;
    end
  end

  // Counting is armed by the FSM, then advances only while the engine runs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_w_q  <= 1'b0;
      computed_q <= '0;
    end else if (clear_i || count_w_clr_i) begin
      count_w_q  <= 1'b0;
      computed_q <= '0;
    end else begin
      if (count_w_set_i)
        count_w_q <= 1'b1;
      if (count_w_q && reg_enable_i)
        computed_q <= computed_q + 16'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_w_row_q <= 1'b0;
    end else if (clear_i || last_row_clr_i) begin
      last_w_row_q <= 1'b0;
    end else if (last_row_set_i) begin
      last_w_row_q <= 1'b1;
    end
  end

  assign rows_reached_height_o = (row_inc_d == height_cnt);
  assign rows_at_iters_o       = (row_q == w_iters_i);
  assign count_w_o             = count_w_q;
  assign last_w_row_o          = last_w_row_q;
  assign tile_row_done_o       = (computed_q == tile_end_cnt);
  assign last_tile_done_o      = (computed_q == last_tile_cnt);

endmodule

`default_nettype wire

// File: verilog/store_counter.sv
// Counter of completed output tile stores with final store flag
`timescale 1ns/1ps
`default_nettype none

module store_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  redmule_ctrl_pkg::cnt_t tot_stores_i,
  input  logic                   store_inc_i,
  input  logic                   store_clr_i,
  output logic                   last_store_o
);

  redmule_ctrl_pkg::cnt_t store_q;
  redmule_ctrl_pkg::cnt_t last_idx;

  // Index of the store that ends the job
  assign last_idx = tot_stores_i - 16'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_q <= '0;
    end else if (clear_i || store_clr_i) begin
      store_q <= '0;
    end else if (store_inc_i) begin
      store_q <= store_q + 16'd1;
    end
  end

  assign last_store_o = (store_q == last_idx);

endmodule

`default_nettype wire

// File: ctrl_fsm/accum_ctrl.sv
// Accumulate enable for the engine with stall masking
`timescale 1ns/1ps
`default_nettype none

module accum_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic reg_enable_i,
  input  logic acc_set_i,
  input  logic acc_clr_i,
  output logic acc_active_o,
  output logic accumulate_o
);

  logic acc_q;
  logic mask_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= 1'b0;
    end else if (clear_i || acc_clr_i) begin
      acc_q <= 1'b0;
    end else if (acc_set_i) begin
      acc_q <= 1'b1;
    end
  end

  // Stall caught while not accumulating holds accumulate off until re-enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= 1'b0;
    end else if (clear_i || reg_enable_i) begin
      mask_q <= 1'b0;
    end else if (!acc_q) begin
      mask_q <= 1'b1;
    end
  end

  assign acc_active_o = acc_q;
  assign accumulate_o = acc_q & ~mask_q;

endmodule

`default_nettype wire

// File: ctrl_fsm/ctrl_fsm.sv
// Job phase FSM driving counter strobes, engine controls and scheduler signals
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic start_i,
  input  logic w_loaded_i,
  input  logic reg_enable_i,
  input  logic z_full_i,
  input  logic z_empty_i,
  input  logic rows_reached_height_i,
  input  logic rows_at_iters_i,
  input  logic count_w_i,
  input  logic last_w_row_i,
  input  logic tile_row_done_i,
  input  logic last_tile_done_i,
  input  logic last_store_i,
  input  logic acc_active_i,
  output logic row_inc_o,
  output logic row_set_one_o,
  output logic row_clr_o,
  output logic count_w_set_o,
  output logic count_w_clr_o,
  output logic last_row_set_o,
  output logic last_row_clr_o,
  output logic store_inc_o,
  output logic store_clr_o,
  output logic acc_set_o,
  output logic acc_clr_o,
  output logic busy_o,
  output logic done_o,
  output logic flush_o,
  output logic w_shift_o,
  output logic z_fill_o,
  output logic z_buffer_clk_en_o,
  output logic sched_first_load_o,
  output logic sched_storing_o,
  output logic sched_finished_o,
  output logic sched_rst_o
);

  redmule_ctrl_pkg::ctrl_state_e state_q;
  redmule_ctrl_pkg::ctrl_state_e state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= redmule_ctrl_pkg::IDLE;
    end else if (clear_i) begin
      state_q <= redmule_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d            = state_q;
    row_inc_o          = 1'b0;
    row_set_one_o      = 1'b0;
    row_clr_o          = 1'b0;
    count_w_set_o      = 1'b0;
    count_w_clr_o      = 1'b0;
    last_row_set_o     = 1'b0;
    last_row_clr_o     = 1'b0;
    store_inc_o        = 1'b0;
    store_clr_o        = 1'b0;
    acc_set_o          = 1'b0;
    acc_clr_o          = 1'b0;
    busy_o             = 1'b1;
    done_o             = 1'b0;
    flush_o            = 1'b0;
    w_shift_o          = 1'b1;
    z_fill_o           = 1'b0;
    z_buffer_clk_en_o  = 1'b0;
    sched_first_load_o = 1'b0;
    sched_storing_o    = 1'b0;
    sched_finished_o   = 1'b0;
    sched_rst_o        = 1'b0;

    case (state_q)
      redmule_ctrl_pkg::IDLE: begin
        busy_o            = 1'b0;
        w_shift_o         = 1'b0;
        row_clr_o         = 1'b1;
        store_clr_o       = 1'b1;
        z_buffer_clk_en_o = clear_i;
        if (start_i)
          state_d = redmule_ctrl_pkg::STARTING;
      end

      redmule_ctrl_pkg::STARTING: begin
        w_shift_o          = 1'b0;
        sched_first_load_o = 1'b1;
        row_inc_o          = 1'b1;
        if (w_loaded_i)
          state_d = redmule_ctrl_pkg::COMPUTING;
      end

      redmule_ctrl_pkg::COMPUTING: begin
        row_inc_o = 1'b1;
        // Arm weight counting once the array is full or the rows run out
        if (rows_reached_height_i && !count_w_i) begin
          count_w_set_o = 1'b1;
        end else if (rows_at_iters_i) begin
          count_w_set_o  = !count_w_i;
          last_row_set_o = !last_w_row_i;
        end
        if (!last_w_row_i) begin
          if (tile_row_done_i) begin
            acc_set_o     = !acc_active_i;
            count_w_clr_o = count_w_i;
          end
        end else if (last_tile_done_i && reg_enable_i) begin
          // Last tile drained, rows restart at one for the next round
          row_inc_o     = 1'b0;
          row_set_one_o = 1'b1;
          acc_clr_o     = acc_active_i;
          count_w_clr_o = count_w_i;
          state_d       = redmule_ctrl_pkg::BUFFERING;
        end
      end

      redmule_ctrl_pkg::BUFFERING: begin
        z_buffer_clk_en_o = 1'b1;
        last_row_clr_o    = last_w_row_i;
        row_inc_o         = 1'b1;
        z_fill_o          = reg_enable_i;
        if (z_full_i) begin
          acc_set_o = 1'b1;
          state_d   = redmule_ctrl_pkg::STORING;
        end
      end

      redmule_ctrl_pkg::STORING: begin
        sched_storing_o = 1'b1;
        row_inc_o       = 1'b1;
        if (z_empty_i) begin
          store_inc_o = 1'b1;
          if (last_store_i) begin
            store_clr_o      = 1'b1;
            sched_finished_o = 1'b1;
            state_d          = redmule_ctrl_pkg::FINISHED;
          end else begin
            state_d = redmule_ctrl_pkg::COMPUTING;
          end
        end
      end

      redmule_ctrl_pkg::FINISHED: begin
        busy_o           = 1'b0;
        done_o           = 1'b1;
        flush_o          = 1'b1;
        sched_rst_o      = 1'b1;
        sched_finished_o = 1'b1;
        row_clr_o        = 1'b1;
        count_w_clr_o    = 1'b1;
        acc_clr_o        = 1'b1;
        last_row_clr_o   = 1'b1;
        store_clr_o      = 1'b1;
        state_d          = redmule_ctrl_pkg::IDLE;
      end

      default: state_d = redmule_ctrl_pkg::IDLE;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/redmule_ctrl_top.sv
// Controller top level connecting register stage, FSM and helper counters
`timescale 1ns/1ps
`default_nettype none

module redmule_ctrl_top #(
  parameter int unsigned Height = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_we_i,
  input  logic                        cfg_re_i,
  input  redmule_ctrl_pkg::reg_addr_t cfg_addr_i,
  input  redmule_ctrl_pkg::reg_data_t cfg_wdata_i,
  output redmule_ctrl_pkg::reg_data_t cfg_rdata_o,
  input  logic                        w_loaded_i,
  input  logic                        reg_enable_i,
  input  logic                        z_full_i,
  input  logic                        z_empty_i,
  output logic                        busy_o,
  output logic                        done_o,
  output logic                        flush_o,
  output logic                        accumulate_o,
  output logic                        w_shift_o,
  output logic                        z_fill_o,
  output logic                        z_buffer_clk_en_o,
  output logic                        sched_first_load_o,
  output logic                        sched_storing_o,
  output logic                        sched_finished_o,
  output logic                        sched_rst_o
);

  redmule_ctrl_pkg::cnt_t w_iters;
  redmule_ctrl_pkg::cnt_t tot_stores;
  logic clear, start;
  logic row_inc, row_set_one, row_clr, count_w_set, count_w_clr;
  logic last_row_set, last_row_clr, store_inc, store_clr, acc_set, acc_clr;
  logic rows_reached_height, rows_at_iters, count_w, last_w_row;
  logic tile_row_done, last_tile_done, last_store, acc_active;

  ctrl_regfile regfile_i (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_re_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .busy_i (busy_o), .done_i (done_o), .clear_o (clear), .start_o (start),
    .w_iters_o (w_iters), .tot_stores_o (tot_stores)
  );

  row_tracker #(.Height(Height)) rows_i (
    .clk_i, .rst_ni, .clear_i (clear), .w_iters_i (w_iters), .w_loaded_i, .reg_enable_i,
    .row_inc_i (row_inc), .row_set_one_i (row_set_one), .row_clr_i (row_clr),
    .count_w_set_i (count_w_set), .count_w_clr_i (count_w_clr),
    .last_row_set_i (last_row_set), .last_row_clr_i (last_row_clr),
    .rows_reached_height_o (rows_reached_height), .rows_at_iters_o (rows_at_iters),
    .count_w_o (count_w), .last_w_row_o (last_w_row),
    .tile_row_done_o (tile_row_done), .last_tile_done_o (last_tile_done)
  );

  store_counter stores_i (
    .clk_i, .rst_ni, .clear_i (clear), .tot_stores_i (tot_stores),
    .store_inc_i (store_inc), .store_clr_i (store_clr), .last_store_o (last_store)
  );

  accum_ctrl accum_i (
    .clk_i, .rst_ni, .clear_i (clear), .reg_enable_i,
    .acc_set_i (acc_set), .acc_clr_i (acc_clr),
    .acc_active_o (acc_active), .accumulate_o
  );

  ctrl_fsm fsm_i (
    .clk_i, .rst_ni, .clear_i (clear), .start_i (start),
    .w_loaded_i, .reg_enable_i, .z_full_i, .z_empty_i,
    .rows_reached_height_i (rows_reached_height), .rows_at_iters_i (rows_at_iters),
    .count_w_i (count_w), .last_w_row_i (last_w_row),
    .tile_row_done_i (tile_row_done), .last_tile_done_i (last_tile_done),
    .last_store_i (last_store), .acc_active_i (acc_active),
    .row_inc_o (row_inc), .row_set_one_o (row_set_one), .row_clr_o (row_clr),
    .count_w_set_o (count_w_set), .count_w_clr_o (count_w_clr),
    .last_row_set_o (last_row_set), .last_row_clr_o (last_row_clr),
    .store_inc_o (store_inc), .store_clr_o (store_clr),
    .acc_set_o (acc_set), .acc_clr_o (acc_clr),
    .busy_o, .done_o, .flush_o, .w_shift_o, .z_fill_o, .z_buffer_clk_en_o,
    .sched_first_load_o, .sched_storing_o, .sched_finished_o, .sched_rst_o
  );

endmodule

`default_nettype wire

// File: verif/redmule_ctrl_chk.sv
// Concurrent assertions on the end-of-job pulse and stall behavior
`timescale 1ns/1ps
`default_nettype none

module redmule_ctrl_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic reg_enable_i,
  input logic acc_active_i,
  input logic busy_o,
  input logic done_o,
  input logic flush_o,
  input logic sched_rst_o,
  input logic sched_finished_o,
  input logic z_fill_o,
  input logic accumulate_o
);

  done_group_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> flush_o && sched_rst_o && sched_finished_o && !busy_o)
    else $error("done_o not accompanied by flush and scheduler reset");

  done_single_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("done_o longer than one cycle");

  // No Z fill while the engine is stalled
  fill_stall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !reg_enable_i |-> !z_fill_o)
    else $error("z_fill_o high during stall");

  acc_mask_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(reg_enable_i) && !acc_active_i |=> !accumulate_o)
    else $error("accumulate_o not masked after stall");

endmodule

bind redmule_ctrl_top redmule_ctrl_chk chk_i (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .reg_enable_i     (reg_enable_i),
  .acc_active_i     (acc_active),
  .busy_o           (busy_o),
  .done_o           (done_o),
  .flush_o          (flush_o),
  .sched_rst_o      (sched_rst_o),
  .sched_finished_o (sched_finished_o),
  .z_fill_o         (z_fill_o),
  .accumulate_o     (accumulate_o)
);

`default_nettype wire

// File: verif/redmule_ctrl_monitor.sv
// Port monitor with expected-value model, comparisons and error counting
`timescale 1ns/1ps
`default_nettype none

module redmule_ctrl_monitor (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_we_i,
  input  logic                        cfg_re_i,
  input  redmule_ctrl_pkg::reg_addr_t cfg_addr_i,
  input  redmule_ctrl_pkg::reg_data_t cfg_wdata_i,
  input  redmule_ctrl_pkg::reg_data_t cfg_rdata_i,
  input  logic                        w_loaded_i,
  input  logic                        reg_enable_i,
  input  logic                        busy_i,
  input  logic                        done_i,
  input  logic                        flush_i,
  input  logic                        accumulate_i,
  input  logic                        w_shift_i,
  input  logic                        z_fill_i,
  input  logic                        z_buffer_clk_en_i,
  input  logic                        sched_first_load_i,
  input  logic                        sched_storing_i,
  input  logic                        sched_finished_i,
  input  logic                        sched_rst_i,
  output int                          error_cnt_o
);

  redmule_ctrl_pkg::cnt_t      w_iters_q;
  redmule_ctrl_pkg::cnt_t      tot_q;
  redmule_ctrl_pkg::cnt_t      stores_seen;
  redmule_ctrl_pkg::reg_data_t exp_rd;
  logic                        busy_exp;
  logic                        first_exp;
  logic                        sticky;
  logic                        storing_q;
  logic                        done_q;
  logic                        en_q;
  logic                        acc_chk;
  logic [1:0]                  trig_p;
  logic [1:0]                  clr_p;
  logic [9:0]                  outs;
  int                          errors;

  assign error_cnt_o = errors;
  assign outs = {busy_i, done_i, flush_i, accumulate_i, w_shift_i, z_fill_i,
                 sched_first_load_i, sched_storing_i, sched_finished_i, sched_rst_i};

  task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
  endtask

  task automatic fail(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  initial errors = 0;

  // Sampled at the falling edge where all ports are settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      w_iters_q   = '0;
      tot_q       = '0;
      stores_seen = '0;
      busy_exp    = 1'b0;
      first_exp   = 1'b0;
      sticky      = 1'b0;
      storing_q   = 1'b0;
      done_q      = 1'b0;
      en_q        = 1'b1;
      acc_chk     = 1'b0;
      trig_p      = '0;
      clr_p       = '0;
      if (outs != '0)
        report("outputs in reset", 32'(outs), 32'd0);
    end else begin
      // Trigger and clear take effect two cycles after the write
      if (trig_p[1]) begin
        busy_exp    = 1'b1;
        first_exp   = 1'b1;
        sticky      = 1'b0;
        stores_seen = '0;
      end
      if (clr_p[1]) begin
        busy_exp  = 1'b0;
        first_exp = 1'b0;
        sticky    = 1'b0;
      end
      if (done_i) begin
        if (!busy_exp)
          fail("done_o pulsed with no job running");
        else if (stores_seen != tot_q)
          report("sched_storing_o rises", 32'(stores_seen), 32'(tot_q));
        if (!(flush_i && sched_rst_i && sched_finished_i))
          fail("done_o without flush_o, sched_rst_o and sched_finished_o");
        if (done_q)
          fail("done_o high for more than one cycle");
        busy_exp = 1'b0;
      end else if (flush_i || sched_rst_i) begin
        fail("flush_o or sched_rst_o high without done_o");
      end
      if (busy_i !== busy_exp)
        report("busy_o", 32'(busy_i), 32'(busy_exp));
      if (sched_first_load_i !== first_exp)
        report("sched_first_load_o", 32'(sched_first_load_i), 32'(first_exp));
      if (z_fill_i && !reg_enable_i)
        fail("z_fill_o high while the engine is stalled");
      if (z_fill_i && !z_buffer_clk_en_i)
        fail("z_fill_o high while the Z buffer clock is disabled");
      // One cycle after a stall began with accumulation off
      if (acc_chk && accumulate_i)
        report("accumulate_o", 32'(accumulate_i), 32'd0);
      if (cfg_re_i) begin
        case (cfg_addr_i)
          redmule_ctrl_pkg::ADDR_W_ITERS:    exp_rd = {16'b0, w_iters_q};
          redmule_ctrl_pkg::ADDR_TOT_STORES: exp_rd = {16'b0, tot_q};
          redmule_ctrl_pkg::ADDR_STATUS:     exp_rd = {30'b0, sticky, busy_exp};
          default:                           exp_rd = '0;
        endcase
        if (cfg_rdata_i !== exp_rd)
          report("cfg_rdata_o", cfg_rdata_i, exp_rd);
      end
      // Model updates visible from the next cycle
      if (sched_storing_i && !storing_q)
        stores_seen++;
      if (done_i)
        sticky = 1'b1;
      if (w_loaded_i)
        first_exp = 1'b0;
      acc_chk = en_q && !reg_enable_i && !accumulate_i;
      en_q    = reg_enable_i;
      trig_p = {trig_p[0], cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_TRIGGER)};
      clr_p  = {clr_p[0], cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_CLEAR)};
      if (cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_W_ITERS))
        w_iters_q = cfg_wdata_i[15:0];
      if (cfg_we_i && (cfg_addr_i == redmule_ctrl_pkg::ADDR_TOT_STORES))
        tot_q = cfg_wdata_i[15:0];
      storing_q = sched_storing_i;
      done_q    = done_i;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_redmule_ctrl.sv
// Testbench with clock, reset, job table, register driver and engine model
`timescale 1ns/1ps
`default_nettype none

module tb_redmule_ctrl;

  localparam int unsigned Height = 4;
  localparam int NumJobs = 5;

  // Job table of weight iterations, stores, clear delay in cycles and stall enable
  int w_iters_tab[NumJobs]  = '{1, 4, 3, 2, 4};
  int stores_tab[NumJobs]   = '{2, 3, 4, 2, 1};
  int clear_tab[NumJobs]    = '{0, 0, 12, 0, 0};
  int stall_tab[NumJobs]    = '{0, 1, 0, 1, 0};

  logic clk_i;
  logic rst_ni;
  logic cfg_we;
  logic cfg_re;
  redmule_ctrl_pkg::reg_addr_t cfg_addr;
  redmule_ctrl_pkg::reg_data_t cfg_wdata;
  redmule_ctrl_pkg::reg_data_t cfg_rdata;
  logic w_loaded, reg_enable, z_full, z_empty;
  logic busy_o, done_o, flush_o, accumulate_o, w_shift_o, z_fill_o, z_buffer_clk_en_o;
  logic sched_first_load_o, sched_storing_o, sched_finished_o, sched_rst_o;
  logic stall_en;
  logic stall_now;
  int   err_cnt;
  int   seed;
  int   gap;
  int   fill_cnt;
  int   st_cnt;
  int   limit;

  redmule_ctrl_top #(.Height(Height)) dut_i (
    .clk_i, .rst_ni, .cfg_we_i (cfg_we), .cfg_re_i (cfg_re), .cfg_addr_i (cfg_addr),
    .cfg_wdata_i (cfg_wdata), .cfg_rdata_o (cfg_rdata), .w_loaded_i (w_loaded),
    .reg_enable_i (reg_enable), .z_full_i (z_full), .z_empty_i (z_empty),
    .busy_o, .done_o, .flush_o, .accumulate_o, .w_shift_o, .z_fill_o, .z_buffer_clk_en_o,
    .sched_first_load_o, .sched_storing_o, .sched_finished_o, .sched_rst_o
  );

  redmule_ctrl_monitor mon_i (
    .clk_i, .rst_ni, .cfg_we_i (cfg_we), .cfg_re_i (cfg_re), .cfg_addr_i (cfg_addr),
    .cfg_wdata_i (cfg_wdata), .cfg_rdata_i (cfg_rdata), .w_loaded_i (w_loaded),
    .reg_enable_i (reg_enable), .busy_i (busy_o), .done_i (done_o), .flush_i (flush_o),
    .accumulate_i (accumulate_o), .w_shift_i (w_shift_o), .z_fill_i (z_fill_o),
    .z_buffer_clk_en_i (z_buffer_clk_en_o),
    .sched_first_load_i (sched_first_load_o), .sched_storing_i (sched_storing_o),
    .sched_finished_i (sched_finished_o), .sched_rst_i (sched_rst_o), .error_cnt_o (err_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic write_reg(input redmule_ctrl_pkg::reg_addr_t addr, input int data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = 32'(data);
    @(posedge clk_i);
    #2;
    cfg_we = 1'b0;
  endtask

  task automatic read_reg(input redmule_ctrl_pkg::reg_addr_t addr);
    cfg_re   = 1'b1;
    cfg_addr = addr;
    @(posedge clk_i);
    #2;
    cfg_re = 1'b0;
  endtask

  // Engine model that loads weights, stalls and fills and drains the Z buffer
  always @(posedge clk_i) begin
    stall_now = stall_en;
    #2;
    if (!rst_ni) begin
      w_loaded   = 1'b0;
      reg_enable = 1'b1;
      z_full     = 1'b0;
      z_empty    = 1'b0;
      gap        = 0;
      fill_cnt   = 0;
      st_cnt     = 0;
    end else begin
      reg_enable = !(stall_now && (($random(seed) & 3) == 0));
      w_loaded   = 1'b0;
      if (gap != 0)
        gap--;
      else if (sched_first_load_o || (busy_o && !z_buffer_clk_en_o && !sched_storing_o)) begin
        w_loaded = 1'b1;
        gap      = 2 + ($random(seed) & 3);
      end
      if (!busy_o || sched_storing_o)
        fill_cnt = 0;
      else if (z_fill_o || fill_cnt != 0)
        fill_cnt++;
      z_full = (fill_cnt >= 3);
      if (sched_storing_o)
        st_cnt++;
      else
        st_cnt = 0;
      z_empty = (st_cnt == 3);
    end
  end

  // Watchdog sized from the job table
  initial begin
    limit = 2000;
    for (int i = 0; i < NumJobs; i++)
      limit += (w_iters_tab[i] + Height) * stores_tab[i] * 40;
    repeat (limit) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", limit);
    $display("Test failures found");
    $finish;
  end

  initial begin
    seed      = 24052;
    rst_ni    = 1'b0;
    cfg_we    = 1'b0;
    cfg_re    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    stall_en  = 1'b0;
    w_loaded  = 1'b0;
    reg_enable = 1'b1;
    z_full    = 1'b0;
    z_empty   = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #2;
    read_reg(redmule_ctrl_pkg::ADDR_STATUS);
    for (int j = 0; j < NumJobs; j++) begin
      stall_en = (stall_tab[j] != 0);
      write_reg(redmule_ctrl_pkg::ADDR_W_ITERS, w_iters_tab[j]);
      write_reg(redmule_ctrl_pkg::ADDR_TOT_STORES, stores_tab[j]);
      read_reg(redmule_ctrl_pkg::ADDR_W_ITERS);
      read_reg(redmule_ctrl_pkg::ADDR_TOT_STORES);
      write_reg(redmule_ctrl_pkg::ADDR_TRIGGER, 1);
      if (clear_tab[j] != 0) begin
        repeat (clear_tab[j]) @(posedge clk_i);
        #2;
        write_reg(redmule_ctrl_pkg::ADDR_CLEAR, 1);
        repeat (4) @(posedge clk_i);
        #2;
      end else begin
        do begin
          @(posedge clk_i);
          #2;
        end while (!done_o);
        @(posedge clk_i);
        #2;
      end
      stall_en = 1'b0;
      read_reg(redmule_ctrl_pkg::ADDR_STATUS);
      repeat (3) @(posedge clk_i);
      #2;
    end
    repeat (5) @(posedge clk_i);
    $display("Run complete: %0d jobs, %0d errors", NumJobs, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/redmule_ctrl_pkg.sv
verilog/ctrl_regfile.sv
verilog/row_tracker.sv
verilog/store_counter.sv
ctrl_fsm/accum_ctrl.sv
ctrl_fsm/ctrl_fsm.sv
verilog/redmule_ctrl_top.sv
verif/redmule_ctrl_chk.sv
verif/redmule_ctrl_monitor.sv
verif/tb_redmule_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f verilog.f \
  --top-module tb_redmule_ctrl -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "All tests passed!" sim.log
